//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbDzCore
RTL_TOP   ?= dzCore
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) \
		-f $(FILELIST)

sim: $(OBJ_DIR)/$(TOP)
	$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- coreArchPkg.sv
package coreArchPkg;

  typedef logic [7:0]  byteT;
  typedef logic [15:0] addrT;
  typedef logic [3:0]  irqT;    // VBlank, LCD status, timer, joypad

  // Codes 0..7 follow the Z80 r field
  typedef enum logic [4:0] {
    selB    = 5'd0,
    selC    = 5'd1,
    selD    = 5'd2,
    selE    = 5'd3,
    selH    = 5'd4,
    selL    = 5'd5,
    selHl   = 5'd6,
    selA    = 5'd7,
    selPc   = 5'd8,
    selX8   = 5'd9,
    selX16  = 5'd10,
    selNone = 5'd11
  } regSelT;

  // ------------------------------------------------------------
  // Fixed addresses

  localparam addrT resetPc   = 16'h0000;
  localparam addrT vecVblank = 16'h0040;
  localparam addrT vecLcd    = 16'h0048;
  localparam addrT vecTimer  = 16'h0050;
  localparam addrT vecJoypad = 16'h0060;

endpackage

//--- coreUopPkg.sv
package coreUopPkg;

  typedef enum logic [4:0] {
    nop,
    sma,      // Select memory address, raise read request
    srm,      // Memory byte into register
    smw,      // Register to memory
    sx8r,     // Opcode source register into X8
    lx16,     // X16 = {mem, X8}
    spc,
    jint,
    z801bop,  // LD r,r' / AND / XOR
    seti,
    ceti
  } uopCmdT;

  typedef struct packed {
    logic                incPc;
    logic                eof;
    uopCmdT              cmd;
    coreArchPkg::regSelT operand;
  } uopT;

  // Register file write request from the executer
  typedef struct packed {
    logic                we;
    coreArchPkg::regSelT dest;
    coreArchPkg::addrT   data;
    logic                pcLoad;
    logic                addrLoad;  // Address select takes readSel
  } regWriteT;

  typedef logic [5:0] uPcT;

  // ------------------------------------------------------------
  // Flow entry points in the microcode ROM

  localparam uPcT flowNop     = 6'd0;
  localparam uPcT flowLdReg   = 6'd1;
  localparam uPcT flowEi      = 6'd2;
  localparam uPcT flowDi      = 6'd3;
  localparam uPcT flowIrq     = 6'd4;
  localparam uPcT flowStoreHl = 6'd5;   // 4 uops
  localparam uPcT flowJp      = 6'd9;   // 4 uops
  localparam uPcT flowLdImm   = 6'd13;  // 2 uops per destination r

  typedef enum logic [1:0] {
    afterReset,
    startFlow,
    runFlow,
    endFlow
  } seqStateT;

endpackage

//--- dzCore.sv
module dzCore (
  input  logic              iClock,
  input  logic              rst,
  input  coreArchPkg::byteT mcuDataIn,
  output coreArchPkg::byteT mcuDataOut,
  output coreArchPkg::addrT mcuAddr,
  output logic              mcuReadRequest,
  output logic              mcuWe,
  input  coreArchPkg::irqT  irqRequests
);
  import coreArchPkg::*;
  import coreUopPkg::*;

  uPcT      uPc;
  uPcT      opFlow;
  uopT      uop;
  logic     flowEnable;
  logic     irqPending;
  addrT     irqVector;
  regWriteT regWrite;
  regSelT   readSel;
  addrT     regData;
  byteT     regA;

  // ------------------------------------------------------------
  // Sequencing

  flowSequencer sequencer (
    .iClock(iClock), .rst(rst),
    .opFlow(opFlow), .irqPending(irqPending), .uop(uop),
    .uPc(uPc), .flowEnable(flowEnable)
  );

  microcodeRom rom (
    .opcode(mcuDataIn), .uPc(uPc), .opFlow(opFlow), .uop(uop)
  );

  // ------------------------------------------------------------
  // Datapath

  registerFile regs (
    .iClock(iClock), .rst(rst),
    .flowEnable(flowEnable), .incPc(uop.incPc),
    .regWrite(regWrite), .readSel(readSel),
    .regData(regData), .regA(regA),
    .mcuAddr(mcuAddr), .mcuDataOut(mcuDataOut)
  );

  uopExecute exec (
    .uop(uop), .flowEnable(flowEnable), .mcuDataIn(mcuDataIn),
    .regData(regData), .regA(regA), .irqVector(irqVector),
    .readSel(readSel), .regWrite(regWrite),
    .mcuReadRequest(mcuReadRequest), .mcuWe(mcuWe)
  );

  interruptUnit irq (
    .iClock(iClock), .rst(rst),
    .flowEnable(flowEnable), .cmd(uop.cmd), .irqRequests(irqRequests),
    .irqPending(irqPending), .irqVector(irqVector)
  );

endmodule

//--- flowSequencer.sv
module flowSequencer (
  input  logic              iClock,
  input  logic              rst,
  input  coreUopPkg::uPcT   opFlow,
  input  logic              irqPending,
  input  coreUopPkg::uopT   uop,
  output coreUopPkg::uPcT   uPc,
  output logic              flowEnable
);
  import coreUopPkg::*;

  seqStateT state;
  seqStateT nextState;

  always_comb
  begin
    case (state)
      afterReset: nextState = startFlow;
      startFlow:  nextState = runFlow;
      runFlow:    nextState = uop.eof ? endFlow : runFlow;
      endFlow:    nextState = startFlow;
      default:    nextState = afterReset;
    endcase
  end

  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      state <= afterReset;
      uPc   <= flowNop;
    end
    else
    begin
      state <= nextState;
      if (state == startFlow)
        uPc <= irqPending ? flowIrq : opFlow;  // Pending interrupt wins over opcode
      else if (flowEnable)
        uPc <= uPc + 1'b1;
    end
  end

  assign flowEnable = (state == runFlow);

  // ------------------------------------------------------------

  // Every flow hits its eof before running off the last LD r,n entry
  uPcInRom: assert property (
    @(posedge iClock) disable iff (rst) flowEnable |-> uPc <= flowLdImm + 6'd15);

endmodule

//--- interruptUnit.sv
module interruptUnit (
  input  logic               iClock,
  input  logic               rst,
  input  logic               flowEnable,
  input  coreUopPkg::uopCmdT cmd,
  input  coreArchPkg::irqT   irqRequests,
  output logic               irqPending,
  output coreArchPkg::addrT  irqVector
);
  import coreArchPkg::*;
  import coreUopPkg::*;

  irqT  latch;    // Sticky until serviced
  logic enabled;

  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      latch   <= '0;
      enabled <= 1'b0;
    end
    else
    begin
      if (flowEnable && cmd == jint)
        latch <= '0;
      else
        latch <= latch | irqRequests;
      if (flowEnable && cmd == seti)
        enabled <= 1'b1;
      else if (flowEnable && cmd == ceti)
        enabled <= 1'b0;
    end
  end

  assign irqPending = enabled & (|latch);

  // Lowest bit has priority
  always_comb
  begin
    if (latch[0])      irqVector = vecVblank;
    else if (latch[1]) irqVector = vecLcd;
    else if (latch[2]) irqVector = vecTimer;
    else if (latch[3]) irqVector = vecJoypad;
    else               irqVector = vecVblank;
  end

  // The sequencer only dispatches the interrupt flow on a live request
  jintHasRequest: assert property (
    @(posedge iClock) disable iff (rst) (flowEnable && cmd == jint) |-> latch != '0);

endmodule

//--- microcodeRom.sv
module microcodeRom (
  input  coreArchPkg::byteT opcode,
  input  coreUopPkg::uPcT   uPc,
  output coreUopPkg::uPcT   opFlow,
  output coreUopPkg::uopT   uop
);
  import coreArchPkg::*;
  import coreUopPkg::*;

  uPcT ldOffset;

  function automatic uopT uopOf(logic inc, logic last, uopCmdT cmd, regSelT op);
    uopT u;
    u.incPc   = inc;
    u.eof     = last;
    u.cmd     = cmd;
    u.operand = op;
    return u;
  endfunction

  // ------------------------------------------------------------
  // Opcode to flow

  always_comb
  begin
    opFlow = flowNop;
    casez (opcode)
      8'b00??_?110:  // LD r,n
        if (opcode[5:3] != 3'd6)
          opFlow = flowLdImm + {opcode[5:3], 1'b0};
      8'b0111_0???:  // LD (HL),r, HALT stays NOP
        if (opcode[2:0] != 3'd6)
          opFlow = flowStoreHl;
      8'b01??_????:
        if (opcode[2:0] != 3'd6 && opcode[5:3] != 3'd6)
          opFlow = flowLdReg;
      8'b1010_????:  // AND r, XOR r
        if (opcode[2:0] != 3'd6)
          opFlow = flowLdReg;
      8'hc3: opFlow = flowJp;
      8'hfb: opFlow = flowEi;
      8'hf3: opFlow = flowDi;
      default: opFlow = flowNop;
    endcase
  end

  // ------------------------------------------------------------
  // Microinstruction store

  assign ldOffset = uPc - flowLdImm;

  always_comb
  begin
    case (uPc)
      flowNop:         uop = uopOf(1'b1, 1'b1, nop, selNone);
      flowLdReg:       uop = uopOf(1'b1, 1'b1, z801bop, selNone);
      flowEi:          uop = uopOf(1'b1, 1'b1, seti, selNone);
      flowDi:          uop = uopOf(1'b1, 1'b1, ceti, selNone);
      flowIrq:         uop = uopOf(1'b0, 1'b1, jint, selNone);
      flowStoreHl:     uop = uopOf(1'b1, 1'b0, sx8r, selNone);
      flowStoreHl + 1: uop = uopOf(1'b0, 1'b0, sma, selHl);
      flowStoreHl + 2: uop = uopOf(1'b0, 1'b0, smw, selX8);
      flowStoreHl + 3: uop = uopOf(1'b0, 1'b1, sma, selPc);  // Back to fetch
      flowJp:          uop = uopOf(1'b1, 1'b0, nop, selNone);
      flowJp + 1:      uop = uopOf(1'b1, 1'b0, srm, selX8);    // Low byte
      flowJp + 2:      uop = uopOf(1'b1, 1'b0, lx16, selNone); // High byte
      flowJp + 3:      uop = uopOf(1'b0, 1'b1, spc, selX16);
      default:
        if (uPc >= flowLdImm && !ldOffset[0])
          uop = uopOf(1'b1, 1'b0, nop, selNone);
        else if (uPc >= flowLdImm)
          uop = uopOf(1'b1, 1'b1, srm, regSelT'({2'b00, ldOffset[3:1]}));
        else
          uop = uopOf(1'b1, 1'b1, nop, selNone);
    endcase
  end

endmodule

//--- registerFile.sv
module registerFile (
  input  logic                 iClock,
  input  logic                 rst,
  input  logic                 flowEnable,
  input  logic                 incPc,
  input  coreUopPkg::regWriteT regWrite,
  input  coreArchPkg::regSelT  readSel,
  output coreArchPkg::addrT    regData,
  output coreArchPkg::byteT    regA,
  output coreArchPkg::addrT    mcuAddr,
  output coreArchPkg::byteT    mcuDataOut
);
  import coreArchPkg::*;

  byteT   regB, regC, regD, regE, regH, regL, regX8;
  addrT   regX16;
  addrT   pc;
  regSelT addrSel;

  function automatic addrT readMux(regSelT sel);
    case (sel)
      selB:    return {8'h00, regB};
      selC:    return {8'h00, regC};
      selD:    return {8'h00, regD};
      selE:    return {8'h00, regE};
      selH:    return {8'h00, regH};
      selL:    return {8'h00, regL};
      selHl:   return {regH, regL};
      selA:    return {8'h00, regA};
      selPc:   return pc;
      selX8:   return {8'h00, regX8};
      selX16:  return regX16;
      default: return 16'h0000;
    endcase
  endfunction

  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      {regB, regC, regD, regE, regH, regL, regA, regX8} <= '0;
      regX16  <= '0;
      pc      <= resetPc;
      addrSel <= selPc;
    end
    else
    begin
      if (regWrite.we)
      begin
        case (regWrite.dest)
          selB:   regB <= regWrite.data[7:0];
          selC:   regC <= regWrite.data[7:0];
          selD:   regD <= regWrite.data[7:0];
          selE:   regE <= regWrite.data[7:0];
          selH:   regH <= regWrite.data[7:0];
          selL:   regL <= regWrite.data[7:0];
          selHl:
          begin
            regH <= regWrite.data[15:8];  // Pair write splits
            regL <= regWrite.data[7:0];
          end
          selA:   regA   <= regWrite.data[7:0];
          selX8:  regX8  <= regWrite.data[7:0];
          selX16: regX16 <= regWrite.data;
          default: ;
        endcase
      end
      if (regWrite.pcLoad)
        pc <= regWrite.data;
      else if (flowEnable && incPc)
        pc <= pc + 16'd1;
      if (regWrite.addrLoad)
        addrSel <= readSel;
    end
  end

  assign regData    = readMux(readSel);
  assign mcuAddr    = readMux(addrSel);
  assign mcuDataOut = regData[7:0];

endmodule

//--- tbDzCore.sv
module tbDzCore;
  import coreArchPkg::*;

  localparam int clockPeriod  = 8;
  localparam int resetCycles  = 3;
  localparam int idleCycles   = 40;  // Quiet time after the last expected store
  localparam int irqDelay     = 20;
  localparam int budgetReset  = 40;
  localparam int budgetStore  = 400;
  localparam int budgetCopy   = 300;
  localparam int budgetAlu    = 400;
  localparam int budgetJump   = 200;
  localparam int budgetMasked = 300;
  localparam int budgetIrq    = 200;  // Per vector
  localparam int numTests     = 10;
  localparam int testOverhead = resetCycles + idleCycles + irqDelay + 2;
  localparam int watchdogCycles = budgetReset + budgetStore + budgetCopy + budgetAlu
                                + budgetJump + budgetMasked + 4 * budgetIrq
                                + numTests * testOverhead;

  logic iClock;
  logic rst;
  byteT mcuDataIn;
  byteT mcuDataOut;
  addrT mcuAddr;
  logic mcuReadRequest;
  logic mcuWe;
  irqT  irqRequests;

  byteT   mem [0:65535];
  addrT   wrAddr[$];
  byteT   wrData[$];
  addrT   expAddr[$];
  byteT   expData[$];
  int     readRequests;
  addrT   progPtr;
  integer seed;
  int     errorCount;
  int     errorsAtStart;
  int     testsRun;
  int     testsFailed;
  string  testName;

  dzCore DUT (
    .iClock(iClock), .rst(rst),
    .mcuDataIn(mcuDataIn), .mcuDataOut(mcuDataOut), .mcuAddr(mcuAddr),
    .mcuReadRequest(mcuReadRequest), .mcuWe(mcuWe),
    .irqRequests(irqRequests)
  );

  initial iClock = 1'b0;
  always #(clockPeriod / 2) iClock = ~iClock;

  // ------------------------------------------------------------
  // Memory model, combinational read

  assign mcuDataIn = mem[mcuAddr];

  always @(posedge iClock)
  begin
    if (mcuWe)
    begin
      mem[mcuAddr] <= mcuDataOut;
      wrAddr.push_back(mcuAddr);  // Every store is logged
      wrData.push_back(mcuDataOut);
    end
    if (mcuReadRequest)
      readRequests++;
  end

  // ------------------------------------------------------------
  // Compare tasks

  task automatic checkByte(string what, byteT expected, byteT actual);
    if (actual !== expected)
    begin
      $display("Mismatch in %s, %s: expected 0x%h, actual 0x%h",
               testName, what, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkAddr(string what, addrT expected, addrT actual);
    if (actual !== expected)
    begin
      $display("Mismatch in %s, %s: expected 0x%h, actual 0x%h",
               testName, what, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkFlag(string what, logic expected, logic actual);
    if (actual !== expected)
    begin
      $display("Mismatch in %s, %s: expected %b, actual %b", testName, what, expected, actual);
      errorCount++;
    end
  endtask

  // ------------------------------------------------------------
  // Program builder, Z80 encodings

  function automatic byteT randomByte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic addrT randomStoreAddr();
    addrT a;
    a = {randomByte(), randomByte()};
    a[15] = 1'b1;  // Upper half holds no code
    return a;
  endfunction

  task automatic emit(byteT b);
    mem[progPtr] <= b;
    progPtr = progPtr + 16'd1;
  endtask

  task automatic emitLdImm(regSelT r, byteT n);
    emit({2'b00, r[2:0], 3'b110});
    emit(n);
  endtask

  task automatic emitLdReg(regSelT dst, regSelT src);
    emit({2'b01, dst[2:0], src[2:0]});
  endtask

  task automatic emitStore(regSelT r);
    emit({5'b01110, r[2:0]});
  endtask

  task automatic emitJp(addrT target);
    emit(8'hc3);
    emit(target[7:0]);
    emit(target[15:8]);
  endtask

  task automatic emitSpin();
    emitJp(progPtr);  // Jump to itself
  endtask

  task automatic emitPointHl(addrT a);
    emitLdImm(selH, a[15:8]);
    emitLdImm(selL, a[7:0]);
  endtask

  task automatic expectStore(addrT a, byteT d);
    expAddr.push_back(a);
    expData.push_back(d);
  endtask

  function automatic addrT vectorOf(int bitNum);
    case (bitNum)
      0:       return vecVblank;
      1:       return vecLcd;
      2:       return vecTimer;
      default: return vecJoypad;
    endcase
  endfunction

  function automatic byteT markerOf(int bitNum);
    return 8'hc0 + 8'(bitNum);
  endfunction

  // Each handler stores its own marker through HL and spins
  task automatic placeVectors();
    int i;
    for (i = 0; i < 4; i++)
    begin
      progPtr = vectorOf(i);
      emitLdImm(selA, markerOf(i));
      emitStore(selA);
      emitSpin();
    end
  endtask

  // ------------------------------------------------------------
  // Test sequencing

  task automatic holdReset(string name);
    int i;
    testName      = name;
    errorsAtStart = errorCount;
    @(posedge iClock);
    rst         <= 1'b1;
    irqRequests <= '0;
    repeat (resetCycles - 1) @(posedge iClock);
    for (i = 0; i < 65536; i++)
      mem[i] <= 8'h00;  // NOP everywhere
    wrAddr.delete();
    wrData.delete();
    expAddr.delete();
    expData.delete();
    readRequests = 0;
    progPtr = resetPc;
  endtask

  task automatic releaseReset();
    @(posedge iClock);
    rst <= 1'b0;
  endtask

  task automatic pulseRequests(irqT req, int delay);
    repeat (delay) @(posedge iClock);
    irqRequests <= req;
    @(posedge iClock);
    irqRequests <= '0;
  endtask

  task automatic awaitStores(int budget);
    int cycles;
    cycles = 0;
    while (wrAddr.size() < expAddr.size() && cycles < budget)
    begin
      @(negedge iClock);
      cycles++;
    end
    if (wrAddr.size() < expAddr.size())
    begin
      $display("Test %s timed out: %0d of %0d stores arrived within %0d cycles",
               testName, wrAddr.size(), expAddr.size(), budget);
      errorCount++;
    end
    repeat (idleCycles) @(negedge iClock);
  endtask

  task automatic compareStores();
    int i;
    if (wrAddr.size() != expAddr.size())
    begin
      $display("Test %s saw %0d memory writes where %0d were expected",
               testName, wrAddr.size(), expAddr.size());
      errorCount++;
    end
    // Each store flow selects HL, then PC again
    if (readRequests != 2 * expAddr.size())
    begin
      $display("Mismatch in %s, read requests: expected %0d, actual %0d",
               testName, 2 * expAddr.size(), readRequests);
      errorCount++;
    end
    for (i = 0; i < expAddr.size() && i < wrAddr.size(); i++)
    begin
      checkAddr($sformatf("store %0d address", i), expAddr[i], wrAddr[i]);
      checkByte($sformatf("store %0d data", i), expData[i], wrData[i]);
    end
  endtask

  task automatic finishTest();
    testsRun++;
    if (errorCount == errorsAtStart)
      $display("%-14s ok", testName);
    else
    begin
      testsFailed++;
      $display("%-14s FAILED, %0d errors", testName, errorCount - errorsAtStart);
    end
  endtask

  // ------------------------------------------------------------
  // Directed tests

  task automatic testResetAndNops();
    holdReset("resetAndNops");
    releaseReset();
    @(negedge iClock);
    checkAddr("address after reset", resetPc, mcuAddr);
    checkFlag("write enable after reset", 1'b0, mcuWe);
    checkFlag("read request after reset", 1'b0, mcuReadRequest);
    // First NOP takes 4 cycles with afterReset, then 3 each
    repeat (30) @(negedge iClock);
    checkAddr("PC after ten NOPs", 16'd10, mcuAddr);
    awaitStores(budgetReset);
    compareStores();
    finishTest();
  endtask

  task automatic testLoadStore();
    addrT   target;
    byteT   val;
    regSelT r;
    int     i;
    holdReset("loadStore");
    target = randomStoreAddr();
    emitPointHl(target);
    emitStore(selH);
    expectStore(target, target[15:8]);
    emitStore(selL);
    expectStore(target, target[7:0]);
    for (i = 0; i < 8; i++)
    begin
      if (i < 4 || i == 7)  // B, C, D, E, A
      begin
        r   = regSelT'(5'(i));
        val = randomByte();
        emitLdImm(r, val);
        emitStore(r);
        expectStore(target, val);
      end
    end
    emitSpin();
    releaseReset();
    awaitStores(budgetStore);
    compareStores();
    finishTest();
  endtask

  task automatic testCopy();
    addrT target;
    byteT v1;
    byteT v2;
    holdReset("registerCopy");
    target = randomStoreAddr();
    v1 = randomByte();
    v2 = v1 ^ (randomByte() | 8'h01);  // Never equal to v1
    emitPointHl(target);
    emitLdImm(selB, v1);
    emitLdImm(selA, v2);
    emitLdReg(selC, selB);
    emitLdReg(selD, selA);
    emitLdReg(selE, selC);
    emitStore(selC);
    expectStore(target, v1);
    emitStore(selD);
    expectStore(target, v2);
    emitStore(selE);
    expectStore(target, v1);
    emitSpin();
    releaseReset();
    awaitStores(budgetCopy);
    compareStores();
    finishTest();
  endtask

  task automatic testAlu();
    addrT target;
    byteT a;
    byteT b;
    byteT c;
    holdReset("andXor");
    target = randomStoreAddr();
    a = randomByte();
    b = randomByte();
    c = randomByte();
    emitPointHl(target);
    emitLdImm(selA, a);
    emitLdImm(selB, b);
    emit({5'b10100, 3'(selB)});  // AND B
    emitStore(selA);
    expectStore(target, a & b);
    emitLdImm(selC, c);
    emit({5'b10101, 3'(selC)});  // XOR C
    emitStore(selA);
    expectStore(target, (a & b) ^ c);
    emit({5'b10101, 3'(selA)});  // XOR A clears A
    emitStore(selA);
    expectStore(target, 8'h00);
    emitLdImm(selA, c);
    emit({5'b10100, 3'(selL)});
    emitStore(selA);
    expectStore(target, c & target[7:0]);
    emitSpin();
    releaseReset();
    awaitStores(budgetAlu);
    compareStores();
    finishTest();
  endtask

  task automatic testJump();
    addrT target;
    addrT jumpTo;
    byteT val;
    holdReset("jump");
    target = randomStoreAddr();
    jumpTo = {4'h1, randomByte(), 4'h0};
    val    = randomByte();
    emitPointHl(target);
    emitLdImm(selA, ~val);
    emitJp(jumpTo);
    emitStore(selA);  // Skipped by the jump
    emitSpin();
    progPtr = jumpTo;
    emitLdImm(selA, val);
    emitStore(selA);
    expectStore(target, val);
    emitSpin();
    releaseReset();
    awaitStores(budgetJump);
    compareStores();
    finishTest();
  endtask

  task automatic testIrqMasked();
    addrT target;
    int   i;
    holdReset("irqMasked");
    target = randomStoreAddr();
    emitPointHl(target);
    emit(8'hfb);  // EI, so that DI has something to undo
    emit(8'hf3);  // DI
    for (i = 0; i < 6; i++)
      emit(8'h00);
    emitLdImm(selA, 8'h5a);
    emitStore(selA);
    expectStore(target, 8'h5a);
    emitSpin();
    placeVectors();
    releaseReset();
    pulseRequests(4'hf, irqDelay);
    awaitStores(budgetMasked);
    compareStores();
    finishTest();
  endtask

  task automatic testIrqPriority(int lowest);
    addrT target;
    byteT r;
    irqT  req;
    int   i;
    holdReset($sformatf("irqPriority%0d", lowest));
    target = randomStoreAddr();
    r      = randomByte();
    req    = r[3:0];
    for (i = 0; i < lowest; i++)
      req[i] = 1'b0;
    req[lowest] = 1'b1;
    req[3]      = 1'b1;  // Always a higher request alongside
    emitPointHl(target);
    emit(8'hfb);  // EI
    emitSpin();
    placeVectors();
    expectStore(target, markerOf(lowest));
    releaseReset();
    pulseRequests(req, irqDelay);
    awaitStores(budgetIrq);
    compareStores();
    finishTest();
  endtask

  // ------------------------------------------------------------

  initial
  begin
    #(watchdogCycles * clockPeriod);
    $display("Watchdog expired after %0d cycles before the tests completed", watchdogCycles);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    int i;
    seed         = 32'hbbf9;
    rst          = 1'b1;
    irqRequests  = '0;
    progPtr      = resetPc;
    readRequests = 0;
    errorCount   = 0;
    testsRun     = 0;
    testsFailed  = 0;
    testResetAndNops();
    testLoadStore();
    testCopy();
    testAlu();
    testJump();
    testIrqMasked();
    for (i = 0; i < 4; i++)
      testIrqPriority(i);
    $display("Tests run %0d, failed %0d, check errors %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- uopExecute.sv
module uopExecute (
  input  coreUopPkg::uopT      uop,
  input  logic                 flowEnable,
  input  coreArchPkg::byteT    mcuDataIn,
  input  coreArchPkg::addrT    regData,
  input  coreArchPkg::byteT    regA,
  input  coreArchPkg::addrT    irqVector,
  output coreArchPkg::regSelT  readSel,
  output coreUopPkg::regWriteT regWrite,
  output logic                 mcuReadRequest,
  output logic                 mcuWe
);
  import coreArchPkg::*;
  import coreUopPkg::*;

  regWriteT wr;
  logic     readReq;
  logic     memWe;

  always_comb
  begin
    readSel = uop.operand;
    wr      = '{we: 1'b0, dest: selNone, data: 16'h0000, pcLoad: 1'b0, addrLoad: 1'b0};
    readReq = 1'b0;
    memWe   = 1'b0;
    case (uop.cmd)
      sma:
      begin
        wr.addrLoad = 1'b1;
        readReq     = 1'b1;
      end
      srm:
      begin
        wr.we   = 1'b1;
        wr.dest = uop.operand;
        wr.data = {8'h00, mcuDataIn};
      end
      smw: memWe = 1'b1;  // Data out follows readSel
      sx8r:
      begin
        readSel = regSelT'({2'b00, mcuDataIn[2:0]});
        wr.we   = 1'b1;
        wr.dest = selX8;
        wr.data = regData;
      end
      lx16:
      begin
        readSel = selX8;
        wr.we   = 1'b1;
        wr.dest = selX16;
        wr.data = {mcuDataIn, regData[7:0]};
      end
      spc:
      begin
        wr.pcLoad = 1'b1;
        wr.data   = regData;
      end
      jint:
      begin
        wr.pcLoad = 1'b1;
        wr.data   = irqVector;
      end
      z801bop:
      begin
        // Opcode still on the bus, source in bits 2:0
        readSel = regSelT'({2'b00, mcuDataIn[2:0]});
        wr.we   = 1'b1;
        if (mcuDataIn[7:6] == 2'b01)
        begin
          wr.dest = regSelT'({2'b00, mcuDataIn[5:3]});
          wr.data = regData;
        end
        else if (mcuDataIn[7:3] == 5'b10100)
        begin
          wr.dest = selA;
          wr.data = {8'h00, regA & regData[7:0]};
        end
        else if (mcuDataIn[7:3] == 5'b10101)
        begin
          wr.dest = selA;
          wr.data = {8'h00, regA ^ regData[7:0]};
        end
        else
          wr.we = 1'b0;
      end
      default: ;  // nop, seti, ceti
    endcase
  end

  // Nothing leaves the executer outside runFlow
  assign regWrite.we       = wr.we & flowEnable;
  assign regWrite.dest     = wr.dest;
  assign regWrite.data     = wr.data;
  assign regWrite.pcLoad   = wr.pcLoad & flowEnable;
  assign regWrite.addrLoad = wr.addrLoad & flowEnable;
  assign mcuReadRequest    = readReq & flowEnable;
  assign mcuWe             = memWe & flowEnable;

endmodule

//--- verilog.f
coreArchPkg.sv
coreUopPkg.sv
microcodeRom.sv
flowSequencer.sv
registerFile.sv
uopExecute.sv
interruptUnit.sv
dzCore.sv
tbDzCore.sv
